// File: all.f
logic/uart_alu_pkg.sv
logic/uart_rx.sv
logic/cmd_decoder.sv
logic/alu_execute.sv
logic/uart_tx.sv
logic/uart_alu_top.sv
testbench/uart_alu_tb.sv

// File: logic/alu_execute.sv
`timescale 1ns/1ns
`default_nettype none

module alu_execute (
  input  logic                          i_clk,
  input  logic                          i_rst,
  input  uart_alu_pkg::alu_cmd_t        i_cmd,
  input  logic                          i_cmd_valid,
  output logic                          o_cmd_ready,
  output uart_alu_pkg::alu_result_t     o_res,
  output logic                          o_res_valid,
  input  logic                          i_res_ready
);

  localparam int DATA_W = uart_alu_pkg::DATA_W;
  localparam int SH_W   = $clog2(DATA_W);

  logic [DATA_W:0]           wide;     // value plus carry in the top bit
  logic [DATA_W:0]           shr;      // right shift with a guard bit below
  logic [SH_W-1:0]           shamt;
  uart_alu_pkg::alu_result_t res_next;

  assign o_cmd_ready = !o_res_valid;
  assign shamt       = i_cmd.b[SH_W-1:0]; // b mod 8
  assign shr         = {i_cmd.a, 1'b0} >> shamt;

  always_comb begin
    case (i_cmd.op)
      uart_alu_pkg::OP_ADD: wide = {1'b0, i_cmd.a} + {1'b0, i_cmd.b};
      uart_alu_pkg::OP_SUB: wide = {1'b0, i_cmd.a} - {1'b0, i_cmd.b}; // top bit is borrow
      uart_alu_pkg::OP_AND: wide = {1'b0, i_cmd.a & i_cmd.b};
      uart_alu_pkg::OP_OR:  wide = {1'b0, i_cmd.a | i_cmd.b};
      uart_alu_pkg::OP_XOR: wide = {1'b0, i_cmd.a ^ i_cmd.b};
      uart_alu_pkg::OP_SLL: wide = {1'b0, i_cmd.a} << shamt; // bit out of bit 7
      uart_alu_pkg::OP_SRL: wide = {shr[0], shr[DATA_W:1]};  // bit out of bit 0
      uart_alu_pkg::OP_NOR: wide = {1'b0, ~(i_cmd.a | i_cmd.b)};
      default:              wide = '0;
    endcase
    res_next.value = wide[DATA_W-1:0];
    res_next.carry = wide[DATA_W];
    res_next.zero  = (wide[DATA_W-1:0] == '0);
    res_next.err   = 1'b0;
    if (i_cmd.bad_op) begin
      res_next = '{value: '0, carry: 1'b0, zero: 1'b0, err: 1'b1};
    end
  end

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      o_res_valid <= 1'b0;
    end else if (i_cmd_valid && o_cmd_ready) begin
      o_res_valid <= 1'b1;
    end else if (o_res_valid && i_res_ready) begin
      o_res_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_cmd_valid && o_cmd_ready) begin
      o_res <= res_next;
    end
  end

  // transmitter latches o_res whenever it gets round to it
  a_res_hold: assert property (
    @(posedge i_clk) disable iff (i_rst)
      o_res_valid && !i_res_ready |=> o_res_valid && $stable(o_res)
  );

endmodule

`default_nettype wire

// File: logic/cmd_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module cmd_decoder (
  input  logic                             i_clk,
  input  logic                             i_rst,
  input  logic [uart_alu_pkg::DATA_W-1:0]  i_byte,
  input  logic                             i_byte_valid,
  output uart_alu_pkg::alu_cmd_t           o_cmd,
  output logic                             o_cmd_valid,
  input  logic                             i_cmd_ready
);

  localparam int DATA_W = uart_alu_pkg::DATA_W;

  uart_alu_pkg::dec_state_e state;
  logic                     take; // byte accepted this cycle

  // bytes are only taken while no command is waiting for execute
  assign take = i_byte_valid && !o_cmd_valid;

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      state       <= uart_alu_pkg::WAIT_OP;
      o_cmd_valid <= 1'b0;
    end else begin
      if (o_cmd_valid && i_cmd_ready) begin
        o_cmd_valid <= 1'b0; // handed to execute
      end
      if (take) begin
        case (state)
          uart_alu_pkg::WAIT_OP: state <= uart_alu_pkg::WAIT_A;
          uart_alu_pkg::WAIT_A:  state <= uart_alu_pkg::WAIT_B;
          uart_alu_pkg::WAIT_B: begin
            state       <= uart_alu_pkg::WAIT_OP;
            o_cmd_valid <= 1'b1; // full command assembled
          end
          default: state <= uart_alu_pkg::WAIT_OP;
        endcase
      end
    end
  end

  // command fields, filled one byte at a time
  always_ff @(posedge i_clk) begin
    if (take) begin
      case (state)
        uart_alu_pkg::WAIT_OP: begin
          o_cmd.op     <= uart_alu_pkg::alu_op_e'(i_byte[2:0]);
          o_cmd.bad_op <= |i_byte[DATA_W-1:3]; // operands still collected
        end
        uart_alu_pkg::WAIT_A: o_cmd.a <= i_byte;
        uart_alu_pkg::WAIT_B: o_cmd.b <= i_byte;
        default: ;
      endcase
    end
  end

  // execute frees up long before the next three bytes can arrive
  a_no_drop: assert property (
    @(posedge i_clk) disable iff (i_rst) o_cmd_valid |-> !i_byte_valid
  );

  a_state_legal: assert property (
    @(posedge i_clk) disable iff (i_rst)
      state inside {uart_alu_pkg::WAIT_OP, uart_alu_pkg::WAIT_A, uart_alu_pkg::WAIT_B}
  );

endmodule

`default_nettype wire

// File: logic/uart_alu_pkg.sv
`default_nettype none

package uart_alu_pkg;

  // width of every byte on the serial link and in the datapath
  localparam int DATA_W = 8;

  // opcode sits in the low three bits of the opcode byte
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1, // carry is the borrow
    OP_AND = 3'd2,
    OP_OR  = 3'd3,
    OP_XOR = 3'd4,
    OP_SLL = 3'd5, // shift amount is b mod 8
    OP_SRL = 3'd6,
    OP_NOR = 3'd7
  } alu_op_e;

  // command assembly states of the decoder
  typedef enum logic [1:0] {
    WAIT_OP = 2'd0,
    WAIT_A  = 2'd1,
    WAIT_B  = 2'd2
  } dec_state_e;

  // decoder to execute, 20 bits
  typedef struct packed {
    alu_op_e           op;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic              bad_op; // upper opcode bits were not zero
  } alu_cmd_t;

  // execute to transmitter, 11 bits
  typedef struct packed {
    logic [DATA_W-1:0] value;
    logic              carry;
    logic              zero;
    logic              err;    // set for a rejected opcode
  } alu_result_t;

endpackage

`default_nettype wire

// File: logic/uart_alu_top.sv
`timescale 1ns/1ns
`default_nettype none

module uart_alu_top #(
  parameter int CLKS_PER_BIT = 16
) (
  input  logic i_clk,
  input  logic i_rst,
  input  logic i_rx,
  output logic o_tx
);

  logic [uart_alu_pkg::DATA_W-1:0] rx_byte;
  logic                            rx_byte_valid;
  uart_alu_pkg::alu_cmd_t          cmd;
  logic                            cmd_valid;
  logic                            cmd_ready;
  uart_alu_pkg::alu_result_t       res;
  logic                            res_valid;
  logic                            res_ready;

  uart_rx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_rx (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_rx         (i_rx),
    .o_byte       (rx_byte),
    .o_byte_valid (rx_byte_valid)
  );

  cmd_decoder u_dec (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_byte       (rx_byte),
    .i_byte_valid (rx_byte_valid),
    .o_cmd        (cmd),
    .o_cmd_valid  (cmd_valid),
    .i_cmd_ready  (cmd_ready)
  );

  alu_execute u_exe (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_cmd        (cmd),
    .i_cmd_valid  (cmd_valid),
    .o_cmd_ready  (cmd_ready),
    .o_res        (res),
    .o_res_valid  (res_valid),
    .i_res_ready  (res_ready)
  );

  uart_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_tx (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_res        (res),
    .i_res_valid  (res_valid),
    .o_res_ready  (res_ready),
    .o_tx         (o_tx)
  );

endmodule

`default_nettype wire

// File: logic/uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx #(
  parameter int CLKS_PER_BIT = 16
) (
  input  logic                             i_clk,
  input  logic                             i_rst,
  input  logic                             i_rx,
  output logic [uart_alu_pkg::DATA_W-1:0]  o_byte,
  output logic                             o_byte_valid
);

  localparam int DATA_W = uart_alu_pkg::DATA_W;
  localparam int CNT_W  = $clog2(CLKS_PER_BIT);
  localparam int IDX_W  = $clog2(DATA_W);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(CLKS_PER_BIT / 2 - 1);
  localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(DATA_W - 1);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  rx_state_e         state;
  logic              rx_meta;   // first sync stage
  logic              rx_sync;   // line value used by the fsm
  logic [CNT_W-1:0]  clk_cnt;   // clocks within the current bit
  logic [IDX_W-1:0]  bit_idx;
  logic [DATA_W-1:0] shift_reg;
  logic              bit_tick;  // middle of a data or stop bit

  assign bit_tick = (clk_cnt == CNT_LAST);

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      rx_meta      <= 1'b1; // idle line is high
      rx_sync      <= 1'b1;
      state        <= RX_IDLE;
      clk_cnt      <= '0;
      bit_idx      <= '0;
      o_byte_valid <= 1'b0;
    end else begin
      rx_meta      <= i_rx;
      rx_sync      <= rx_meta;
      o_byte_valid <= 1'b0; // single cycle pulse
      case (state)
        RX_IDLE: begin
          clk_cnt <= '0;
          bit_idx <= '0;
          if (!rx_sync) begin
            state <= RX_START; // falling start edge
          end
        end
        RX_START: begin
          if (clk_cnt == CNT_HALF) begin
            clk_cnt <= '0;
            state   <= rx_sync ? RX_IDLE : RX_DATA; // glitch if high again
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (bit_tick) begin
            clk_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == IDX_LAST) begin
              state <= RX_STOP;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        RX_STOP: begin
          if (bit_tick) begin
            clk_cnt      <= '0;
            state        <= RX_IDLE;
            o_byte_valid <= rx_sync; // a low stop bit drops the byte
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // data path, lsb arrives first
  always_ff @(posedge i_clk) begin
    if (state == RX_DATA && bit_tick) begin
      shift_reg <= {rx_sync, shift_reg[DATA_W-1:1]};
    end
    if (state == RX_STOP && bit_tick && rx_sync) begin
      o_byte <= shift_reg;
    end
  end

  // the decoder relies on one pulse per byte
  a_valid_pulse: assert property (
    @(posedge i_clk) disable iff (i_rst) o_byte_valid |=> !o_byte_valid
  );

endmodule

`default_nettype wire

// File: logic/uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx #(
  parameter int CLKS_PER_BIT = 16
) (
  input  logic                          i_clk,
  input  logic                          i_rst,
  input  uart_alu_pkg::alu_result_t     i_res,
  input  logic                          i_res_valid,
  output logic                          o_res_ready,
  output logic                          o_tx
);

  localparam int DATA_W = uart_alu_pkg::DATA_W;
  localparam int CNT_W  = $clog2(CLKS_PER_BIT);
  localparam int IDX_W  = $clog2(DATA_W);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(DATA_W - 1);

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_e;

  tx_state_e         state;
  logic [CNT_W-1:0]  clk_cnt;
  logic [IDX_W-1:0]  bit_idx;
  logic              second;    // flags frame in progress
  logic [DATA_W-1:0] shift_reg;
  logic [DATA_W-1:0] flags_reg;
  logic              bit_tick;  // last clock of a bit

  assign bit_tick    = (clk_cnt == CNT_LAST);
  assign o_res_ready = (state == TX_IDLE);

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      state   <= TX_IDLE;
      o_tx    <= 1'b1;
      clk_cnt <= '0;
      bit_idx <= '0;
      second  <= 1'b0;
    end else begin
      case (state)
        TX_IDLE: begin
          clk_cnt <= '0;
          bit_idx <= '0;
          if (i_res_valid) begin
            state  <= TX_START;
            o_tx   <= 1'b0; // start bit goes out right away
            second <= 1'b0;
          end
        end
        TX_START: begin
          if (bit_tick) begin
            clk_cnt <= '0;
            state   <= TX_DATA;
            o_tx    <= shift_reg[0];
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        TX_DATA: begin
          if (bit_tick) begin
            clk_cnt <= '0;
            if (bit_idx == IDX_LAST) begin
              state   <= TX_STOP;
              o_tx    <= 1'b1;
              bit_idx <= '0;
            end else begin
              bit_idx <= bit_idx + 1'b1;
              o_tx    <= shift_reg[1]; // next bit after this shift
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        TX_STOP: begin
          if (bit_tick) begin
            clk_cnt <= '0;
            if (!second) begin
              second <= 1'b1;
              state  <= TX_START; // flags frame follows with no gap
              o_tx   <= 1'b0;
            end else begin
              state <= TX_IDLE;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (state == TX_IDLE && i_res_valid) begin
      shift_reg <= i_res.value;
      flags_reg <= {{(DATA_W - 3){1'b0}}, i_res.err, i_res.zero, i_res.carry};
    end else if (state == TX_DATA && bit_tick) begin
      shift_reg <= shift_reg >> 1;
    end else if (state == TX_STOP && bit_tick && !second) begin
      shift_reg <= flags_reg;
    end
  end

endmodule

`default_nettype wire

// File: testbench/uart_alu_cases.txt
# opcode a b frame_err exp_value exp_flags, all hex
# flags byte: bit0 carry, bit1 zero, bit2 bad opcode
00 FF 01 0 00 03
00 7F 01 0 80 00
00 00 00 0 00 02
01 00 01 0 FF 01
01 05 05 0 00 02
01 80 7F 0 01 00
02 F0 0F 0 00 02
02 AA FF 0 AA 00
03 A0 05 0 A5 00
04 5A 5A 0 00 02
04 5A A5 0 FF 00
07 00 00 0 FF 00
07 F0 0F 0 00 02
05 81 00 0 81 00
05 81 01 0 02 01
05 83 07 0 80 01
05 81 09 0 02 01
06 81 00 0 81 00
06 81 01 0 40 01
06 C1 07 0 01 01
06 03 09 0 01 01
06 01 01 0 00 03
28 11 22 0 00 04
00 10 20 0 30 00
FF 00 00 0 00 04
01 10 20 0 F0 01
00 12 34 1 46 00
01 10 20 1 F0 01
02 3C 3C 0 3C 00

// File: testbench/uart_alu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module uart_alu_tb;

  localparam int CLKS_PER_BIT = 16;
  localparam int DATA_W       = uart_alu_pkg::DATA_W;
  localparam int MAX_GAP      = 40; // idle cycles between commands

  typedef struct packed {
    logic [DATA_W-1:0] op;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic              frame_err; // bad frame sent ahead of the command
    logic [DATA_W-1:0] exp_value;
    logic [DATA_W-1:0] exp_flags;
  } case_t;

  logic  i_clk;
  logic  i_rst;
  logic  i_rx;
  logic  o_tx;
  case_t cases[$];
  int    errors;
  int    passed;
  int    cycles;
  int    cycle_limit;

  uart_alu_top #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) dut (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_rx  (i_rx),
    .o_tx  (o_tx)
  );

  always #4 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout: replies did not complete within %0d cycles", cycle_limit);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  task automatic load_cases();
    int                fd;
    string             line;
    logic [DATA_W-1:0] op;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [DATA_W-1:0] fe;
    logic [DATA_W-1:0] ev;
    logic [DATA_W-1:0] ef;
    case_t             c;
    fd = $fopen("testbench/uart_alu_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open testbench/uart_alu_cases.txt");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if ($sscanf(line, "%h %h %h %h %h %h", op, a, b, fe, ev, ef) == 6) begin
        c = '{op: op, a: a, b: b, frame_err: fe[0], exp_value: ev, exp_flags: ef};
        cases.push_back(c);
      end
    end
    $fclose(fd);
  endtask

  // 8N1 frame, lsb first, each bit held for one bit time
  task automatic send_frame(input logic [DATA_W-1:0] data, input logic stop_bit);
    logic [DATA_W+1:0] frame;
    frame = {stop_bit, data, 1'b0};
    for (int i = 0; i < DATA_W + 2; i++) begin
      @(posedge i_clk);
      i_rx <= frame[i];
      repeat (CLKS_PER_BIT - 1) @(posedge i_clk);
    end
  endtask

  task automatic idle_line(input int n);
    @(posedge i_clk);
    i_rx <= 1'b1;
    repeat (n) @(posedge i_clk);
  endtask

  task automatic recv_frame(output logic [DATA_W-1:0] data, output logic stop_ok);
    @(posedge i_clk);
    while (o_tx !== 1'b0) begin // start edge
      assert (o_tx === 1'b1) else begin
        $display("Fail %0t ns: o_tx expected 1 got %b", $time, o_tx);
        errors++;
      end
      @(posedge i_clk);
    end
    repeat (CLKS_PER_BIT / 2 - 1) @(posedge i_clk); // middle of the start bit
    for (int i = 0; i < DATA_W; i++) begin
      repeat (CLKS_PER_BIT) @(posedge i_clk);
      data[i] = o_tx;
    end
    repeat (CLKS_PER_BIT) @(posedge i_clk);
    stop_ok = (o_tx === 1'b1);
  endtask

  task automatic check_byte(input string name, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] got);
    assert (got === exp) else begin
      $display("Fail %0t ns: %s expected %02h got %02h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic drive_cases();
    for (int i = 0; i < cases.size(); i++) begin
      if (cases[i].frame_err) begin
        send_frame(DATA_W'($urandom), 1'b0); // receiver must drop this one
        idle_line(CLKS_PER_BIT);
      end
      send_frame(cases[i].op, 1'b1);
      send_frame(cases[i].a, 1'b1);
      send_frame(cases[i].b, 1'b1);
      idle_line($urandom % (MAX_GAP + 1));
    end
  endtask

  task automatic watch_replies();
    logic [DATA_W-1:0] value;
    logic [DATA_W-1:0] flags;
    logic              stop_v;
    logic              stop_f;
    int                errs_before;
    for (int i = 0; i < cases.size(); i++) begin
      errs_before = errors;
      recv_frame(value, stop_v);
      recv_frame(flags, stop_f);
      assert (stop_v && stop_f) else begin
        $display("reply %0d arrived with a low stop bit at %0t ns", i, $time);
        errors++;
      end
      check_byte("o_tx value byte", cases[i].exp_value, value);
      check_byte("o_tx flags byte", cases[i].exp_flags, flags);
      if (errors == errs_before) begin
        passed++;
      end
      $display("case %0d op=%02h a=%02h b=%02h frame_err=%0d reply=%02h %02h %s",
               i, cases[i].op, cases[i].a, cases[i].b, cases[i].frame_err,
               value, flags, (errors == errs_before) ? "ok" : "FAILED");
    end
  endtask

  // no reply may follow once every command is answered
  task automatic check_quiet_line(input int n);
    int low_cycles;
    low_cycles = 0;
    repeat (n) begin
      @(posedge i_clk);
      if (o_tx !== 1'b1) begin
        low_cycles++;
      end
    end
    assert (low_cycles == 0) else begin
      $display("o_tx left idle for %0d cycles after the last reply", low_cycles);
      errors++;
    end
  endtask

  initial begin
    i_clk       = 1'b0;
    i_rst       = 1'b1;
    i_rx        = 1'b1;
    errors      = 0;
    passed      = 0;
    cycles      = 0;
    cycle_limit = 0;
    void'($urandom(22));
    load_cases();
    assert (cases.size() > 0) else begin
      $display("no cases were read from the case file");
      errors++;
    end
    cycle_limit = cases.size() * 60 * CLKS_PER_BIT + 2000;
    repeat (3) @(posedge i_clk);
    i_rst <= 1'b0;
    repeat (4) @(posedge i_clk);
    assert (o_tx === 1'b1) else begin
      $display("Fail %0t ns: o_tx expected 1 got %b", $time, o_tx);
      errors++;
    end
    fork
      drive_cases();
      watch_replies();
    join
    check_quiet_line(30 * CLKS_PER_BIT);
    $display("cases %0d passed %0d errors %0d", cases.size(), passed, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
